// File: rtl/dds_pkg.sv
package dds_pkg;

    localparam int SAMPLE_W   = 8;
    localparam int PHASE_W    = 32;
    localparam int GAIN_W     = 16;
    localparam int GAIN_RADIX = 8;
    localparam int ROM_DEPTH  = 256;
    localparam int ROM_AW     = $clog2(ROM_DEPTH);

    // byte offsets on the APB bus
    typedef enum logic [7:0] {
        CTRL        = 8'h00,
        RAW         = 8'h04,
        STEP        = 8'h08,
        FM_RAW      = 8'h0C,
        FM_GAIN     = 8'h10,
        FM_OFFSET   = 8'h14,
        AM_RAW      = 8'h18,
        AM_GAIN     = 8'h1C,
        AM_OFFSET   = 8'h20,
        NOISE_GAIN  = 8'h24,
        ROM_WR      = 8'h28,
        STAT_CTRL   = 8'h2C,
        STAT_LIMIT  = 8'h30,
        STAT_MINMAX = 8'h34,
        STAT_COUNT  = 8'h38
    } reg_addr_e;

    // modulation source, code 3 selects zero
    typedef enum logic [1:0] {
        SRC_RAW = 2'd0,
        SRC_INA = 2'd1,
        SRC_INB = 2'd2
    } src_sel_e;

    typedef enum logic [1:0] {
        OUT_RAW = 2'd0,
        OUT_DDS = 2'd1,
        OUT_INA = 2'd2,
        OUT_INB = 2'd3
    } out_sel_e;

    typedef struct packed {
        logic                       enable;
        logic [PHASE_W-1:0]         step;
        src_sel_e                   fm_sel;
        logic signed [SAMPLE_W-1:0] fm_raw;
        logic signed [GAIN_W-1:0]   fm_gain;
        logic signed [PHASE_W-1:0]  fm_offset;
    } dds_cfg_t;

    typedef struct packed {
        out_sel_e                   out_sel;
        logic signed [SAMPLE_W-1:0] raw;
        src_sel_e                   am_sel;
        logic signed [SAMPLE_W-1:0] am_raw;
        logic signed [GAIN_W-1:0]   am_gain;
        logic signed [GAIN_W-1:0]   am_offset;
        logic signed [SAMPLE_W-1:0] noise_gain;
    } mix_cfg_t;

    typedef struct packed {
        logic                valid;
        logic [ROM_AW-1:0]   addr;
        logic [SAMPLE_W-1:0] data;
    } rom_wr_t;

    typedef struct packed {
        logic        clear;
        logic        enable;
        logic [31:0] limit;
    } stat_cfg_t;

    typedef struct packed {
        logic signed [SAMPLE_W-1:0] min;
        logic signed [SAMPLE_W-1:0] max;
        logic [31:0]                count;
    } stat_res_t;

endpackage

// File: rtl/gain_offset_clamp.sv
`timescale 1ns/1ps

module gain_offset_clamp import dds_pkg::*; #(
    parameter int IN_WIDTH     = 8,
    parameter int GAIN_WIDTH   = 16,
    parameter int OFFSET_WIDTH = 8,
    parameter int OUT_WIDTH    = 8
) (
    input  logic                           clk,
    input  logic signed [IN_WIDTH-1:0]     in_data,
    input  logic signed [GAIN_WIDTH-1:0]   gain,
    input  logic signed [OFFSET_WIDTH-1:0] offset,
    output logic signed [OUT_WIDTH-1:0]    out_data
);

    localparam int PROD_W = IN_WIDTH + GAIN_WIDTH;
    localparam int WIDE_W = (PROD_W > OFFSET_WIDTH) ? PROD_W : OFFSET_WIDTH;
    // one guard bit so the add never wraps
    localparam int SUM_W  = ((WIDE_W > OUT_WIDTH) ? WIDE_W : OUT_WIDTH) + 1;

    logic signed [PROD_W-1:0]  prod;
    logic signed [PROD_W-1:0]  scaled;
    logic signed [SUM_W-1:0]   sum;
    logic [SUM_W-OUT_WIDTH:0]  top;

    always_comb begin
        prod   = in_data * gain;
        scaled = prod >>> GAIN_RADIX;
        sum    = scaled + offset;
    end

    // all ones or all zeros above the output sign bit means it fits
    assign top = sum[SUM_W-1:OUT_WIDTH-1];

    always_ff @(posedge clk) begin
        if (&top || ~|top) begin
            out_data <= sum[OUT_WIDTH-1:0];
        end else if (sum[SUM_W-1]) begin
            out_data <= {1'b1, {(OUT_WIDTH-1){1'b0}}};
        end else begin
            out_data <= {1'b0, {(OUT_WIDTH-1){1'b1}}};
        end
    end

endmodule

// File: rtl/dds_regs.sv
`timescale 1ns/1ps

module dds_regs import dds_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [31:0] paddr,
    input  logic [31:0] pwdata,
    input  stat_res_t   stat_res,
    output logic [31:0] prdata,
    output dds_cfg_t    dds_cfg,
    output mix_cfg_t    mix_cfg,
    output rom_wr_t     rom_wr,
    output stat_cfg_t   stat_cfg
);

    reg_addr_e addr;
    logic      addr_hit;
    logic      wr_en;

    assign addr     = reg_addr_e'(paddr[7:0]);
    assign addr_hit = (paddr[31:8] == '0);
    assign wr_en    = psel && penable && pwrite && addr_hit;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            dds_cfg         <= '0;
            mix_cfg         <= '0;
            rom_wr.valid    <= 1'b0;
            stat_cfg        <= '0;
        end else begin
            // pulses last one cycle unless rewritten
            rom_wr.valid   <= 1'b0;
            stat_cfg.clear <= 1'b0;
            if (wr_en) begin
                case (addr)
                    CTRL: begin
                        mix_cfg.out_sel <= out_sel_e'(pwdata[1:0]);
                        dds_cfg.enable  <= pwdata[2];
                        dds_cfg.fm_sel  <= src_sel_e'(pwdata[5:4]);
                        mix_cfg.am_sel  <= src_sel_e'(pwdata[7:6]);
                    end
                    RAW:        mix_cfg.raw        <= pwdata[SAMPLE_W-1:0];
                    STEP:       dds_cfg.step       <= pwdata[PHASE_W-1:0];
                    FM_RAW:     dds_cfg.fm_raw     <= pwdata[SAMPLE_W-1:0];
                    FM_GAIN:    dds_cfg.fm_gain    <= pwdata[GAIN_W-1:0];
                    FM_OFFSET:  dds_cfg.fm_offset  <= pwdata[PHASE_W-1:0];
                    AM_RAW:     mix_cfg.am_raw     <= pwdata[SAMPLE_W-1:0];
                    AM_GAIN:    mix_cfg.am_gain    <= pwdata[GAIN_W-1:0];
                    AM_OFFSET:  mix_cfg.am_offset  <= pwdata[GAIN_W-1:0];
                    NOISE_GAIN: mix_cfg.noise_gain <= pwdata[SAMPLE_W-1:0];
                    ROM_WR: begin
                        rom_wr.valid <= 1'b1;
                        rom_wr.addr  <= pwdata[15:8];
                        rom_wr.data  <= pwdata[7:0];
                    end
                    STAT_CTRL: begin
                        stat_cfg.clear  <= pwdata[0];
                        stat_cfg.enable <= pwdata[1];
                    end
                    STAT_LIMIT: stat_cfg.limit     <= pwdata;
                    default: ;
                endcase
            end
        end
    end

    // read mux, statistics come straight from sig_stats
    always_comb begin
        prdata = '0;
        if (psel && !pwrite && addr_hit) begin
            case (addr)
                CTRL: begin
                    prdata[7:0] = {mix_cfg.am_sel, dds_cfg.fm_sel, 1'b0,
                                   dds_cfg.enable, mix_cfg.out_sel};
                end
                RAW:         prdata = {24'b0, mix_cfg.raw};
                STEP:        prdata = dds_cfg.step;
                FM_RAW:      prdata = {24'b0, dds_cfg.fm_raw};
                FM_GAIN:     prdata = {16'b0, dds_cfg.fm_gain};
                FM_OFFSET:   prdata = dds_cfg.fm_offset;
                AM_RAW:      prdata = {24'b0, mix_cfg.am_raw};
                AM_GAIN:     prdata = {16'b0, mix_cfg.am_gain};
                AM_OFFSET:   prdata = {16'b0, mix_cfg.am_offset};
                NOISE_GAIN:  prdata = {24'b0, mix_cfg.noise_gain};
                STAT_CTRL:   prdata = {30'b0, stat_cfg.enable, 1'b0};
                STAT_LIMIT:  prdata = stat_cfg.limit;
                STAT_MINMAX: prdata = {16'b0, stat_res.max, stat_res.min};
                STAT_COUNT:  prdata = stat_res.count;
                default:     prdata = '0;
            endcase
        end
    end

    // a table write never stretches past one cycle
    a_rom_wr_pulse: assert property (
        @(posedge clk) disable iff (!rst_n) rom_wr.valid |=> !rom_wr.valid
    );

endmodule

// File: rtl/dds_core.sv
`timescale 1ns/1ps

module dds_core import dds_pkg::*; (
    input  logic                       clk,
    input  logic                       rst_n,
    input  dds_cfg_t                   cfg,
    input  rom_wr_t                    rom_wr,
    input  logic signed [SAMPLE_W-1:0] ina_data,
    input  logic signed [SAMPLE_W-1:0] inb_data,
    output logic signed [SAMPLE_W-1:0] dds_sample
);

    logic signed [SAMPLE_W-1:0] fm_src;
    logic signed [PHASE_W-1:0]  fm_delta;
    logic [PHASE_W-1:0]         phase;
    logic [ROM_AW-1:0]          rom_addr;
    logic signed [SAMPLE_W-1:0] wave_rom [ROM_DEPTH];

    always_comb begin
        case (cfg.fm_sel)
            SRC_RAW: fm_src = cfg.fm_raw;
            SRC_INA: fm_src = ina_data;
            SRC_INB: fm_src = inb_data;
            default: fm_src = '0;
        endcase
    end

    // frequency offset, one cycle behind the source
    gain_offset_clamp #(
        .IN_WIDTH     (SAMPLE_W),
        .GAIN_WIDTH   (GAIN_W),
        .OFFSET_WIDTH (PHASE_W),
        .OUT_WIDTH    (PHASE_W)
    ) i_fm_clamp (
        .clk      (clk),
        .in_data  (fm_src),
        .gain     (cfg.fm_gain),
        .offset   (cfg.fm_offset),
        .out_data (fm_delta)
    );

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            phase <= '0;
        end else if (!cfg.enable) begin
            phase <= '0;
        end else begin
            phase <= phase + cfg.step + fm_delta;
        end
    end

    // table indexed by the top phase bits
    assign rom_addr = phase[PHASE_W-1 -: ROM_AW];

    always_ff @(posedge clk) begin
        if (rom_wr.valid) begin
            wave_rom[rom_wr.addr] <= rom_wr.data;
        end
    end

    always_ff @(posedge clk) begin
        dds_sample <= wave_rom[rom_addr];
    end

    a_phase_held: assert property (
        @(posedge clk) disable iff (!rst_n) !cfg.enable |=> (phase == '0)
    );

endmodule

// File: rtl/signal_mixer.sv
`timescale 1ns/1ps

module signal_mixer import dds_pkg::*; (
    input  logic                       clk,
    input  logic                       rst_n,
    input  mix_cfg_t                   cfg,
    input  logic signed [SAMPLE_W-1:0] dds_sample,
    input  logic signed [SAMPLE_W-1:0] ina_data,
    input  logic signed [SAMPLE_W-1:0] inb_data,
    output logic signed [SAMPLE_W-1:0] dds_data_out
);

    logic signed [SAMPLE_W-1:0]   out_src;
    logic signed [SAMPLE_W-1:0]   am_src;
    logic signed [GAIN_W-1:0]     am_factor;
    logic [SAMPLE_W-1:0]          lfsr;
    logic                         lfsr_fb;
    logic signed [2*SAMPLE_W-1:0] noise_prod;
    logic signed [SAMPLE_W-1:0]   stage1_sample;
    logic signed [SAMPLE_W-1:0]   stage1_noise;

    always_comb begin
        case (cfg.out_sel)
            OUT_RAW: out_src = cfg.raw;
            OUT_DDS: out_src = dds_sample;
            OUT_INA: out_src = ina_data;
            default: out_src = inb_data;
        endcase
        case (cfg.am_sel)
            SRC_RAW: am_src = cfg.am_raw;
            SRC_INA: am_src = ina_data;
            SRC_INB: am_src = inb_data;
            default: am_src = '0;
        endcase
    end

    // taps 8 6 5 4, maximal length
    assign lfsr_fb    = lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3];
    assign noise_prod = $signed(lfsr) * cfg.noise_gain;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            lfsr          <= '1;
            stage1_sample <= '0;
            stage1_noise  <= '0;
        end else begin
            lfsr          <= {lfsr[SAMPLE_W-2:0], lfsr_fb};
            stage1_sample <= out_src;
            // upper byte is the arithmetic shift by 8
            stage1_noise  <= noise_prod[2*SAMPLE_W-1:SAMPLE_W];
        end
    end

    // am factor lines up with stage 1
    gain_offset_clamp #(
        .IN_WIDTH     (SAMPLE_W),
        .GAIN_WIDTH   (GAIN_W),
        .OFFSET_WIDTH (GAIN_W),
        .OUT_WIDTH    (GAIN_W)
    ) i_am_clamp (
        .clk      (clk),
        .in_data  (am_src),
        .gain     (cfg.am_gain),
        .offset   (cfg.am_offset),
        .out_data (am_factor)
    );

    gain_offset_clamp #(
        .IN_WIDTH     (SAMPLE_W),
        .GAIN_WIDTH   (GAIN_W),
        .OFFSET_WIDTH (SAMPLE_W),
        .OUT_WIDTH    (SAMPLE_W)
    ) i_modulator (
        .clk      (clk),
        .in_data  (stage1_sample),
        .gain     (am_factor),
        .offset   (stage1_noise),
        .out_data (dds_data_out)
    );

    a_lfsr_live: assert property (
        @(posedge clk) disable iff (!rst_n) lfsr != '0
    );

endmodule

// File: rtl/sig_stats.sv
`timescale 1ns/1ps

module sig_stats import dds_pkg::*; (
    input  logic                       clk,
    input  logic                       rst_n,
    input  stat_cfg_t                  cfg,
    input  logic signed [SAMPLE_W-1:0] sample,
    output stat_res_t                  res
);

    logic take;

    assign take = cfg.enable && (res.count < cfg.limit);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            res <= '0;
        end else if (cfg.clear) begin
            res.min   <= {1'b0, {(SAMPLE_W-1){1'b1}}};
            res.max   <= {1'b1, {(SAMPLE_W-1){1'b0}}};
            res.count <= '0;
        end else if (take) begin
            res.count <= res.count + 1'b1;
            // first sample seeds both extremes, same as folding into a clear
            if (res.count == '0) begin
                res.min <= sample;
                res.max <= sample;
            end else begin
                if (sample < res.min) begin
                    res.min <= sample;
                end
                if (sample > res.max) begin
                    res.max <= sample;
                end
            end
        end
    end

    a_min_le_max: assert property (
        @(posedge clk) disable iff (!rst_n) (res.count != '0) |-> (res.min <= res.max)
    );

endmodule

// File: rtl/dds_block.sv
`timescale 1ns/1ps

module dds_block import dds_pkg::*; (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       psel,
    input  logic                       penable,
    input  logic                       pwrite,
    input  logic [31:0]                paddr,
    input  logic [31:0]                pwdata,
    input  logic signed [SAMPLE_W-1:0] ina_data,
    input  logic signed [SAMPLE_W-1:0] inb_data,
    output logic [31:0]                prdata,
    output logic signed [SAMPLE_W-1:0] dds_data_out
);

    dds_cfg_t                   dds_cfg;
    mix_cfg_t                   mix_cfg;
    rom_wr_t                    rom_wr;
    stat_cfg_t                  stat_cfg;
    stat_res_t                  stat_res;
    logic signed [SAMPLE_W-1:0] dds_sample;

    dds_regs i_regs (
        .clk      (clk),
        .rst_n    (rst_n),
        .psel     (psel),
        .penable  (penable),
        .pwrite   (pwrite),
        .paddr    (paddr),
        .pwdata   (pwdata),
        .stat_res (stat_res),
        .prdata   (prdata),
        .dds_cfg  (dds_cfg),
        .mix_cfg  (mix_cfg),
        .rom_wr   (rom_wr),
        .stat_cfg (stat_cfg)
    );

    dds_core i_core (
        .clk        (clk),
        .rst_n      (rst_n),
        .cfg        (dds_cfg),
        .rom_wr     (rom_wr),
        .ina_data   (ina_data),
        .inb_data   (inb_data),
        .dds_sample (dds_sample)
    );

    signal_mixer i_mixer (
        .clk          (clk),
        .rst_n        (rst_n),
        .cfg          (mix_cfg),
        .dds_sample   (dds_sample),
        .ina_data     (ina_data),
        .inb_data     (inb_data),
        .dds_data_out (dds_data_out)
    );

    // statistics watch the exported output
    sig_stats i_stats (
        .clk    (clk),
        .rst_n  (rst_n),
        .cfg    (stat_cfg),
        .sample (dds_data_out),
        .res    (stat_res)
    );

endmodule

// File: test/tb_dds_block.sv
`timescale 1ns/1ps

module tb_dds_block import dds_pkg::*; ();

    logic                       clk;
    logic                       rst_n;
    logic                       psel;
    logic                       penable;
    logic                       pwrite;
    logic [31:0]                paddr;
    logic [31:0]                pwdata;
    logic signed [SAMPLE_W-1:0] ina_data;
    logic signed [SAMPLE_W-1:0] inb_data;
    logic [31:0]                prdata;
    logic signed [SAMPLE_W-1:0] dds_data_out;

    integer seed = 32'ha0e6f9b3;
    int     checks = 0;
    int     errors = 0;

    dds_block i_dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .psel         (psel),
        .penable      (penable),
        .pwrite       (pwrite),
        .paddr        (paddr),
        .pwdata       (pwdata),
        .ina_data     (ina_data),
        .inb_data     (inb_data),
        .prdata       (prdata),
        .dds_data_out (dds_data_out)
    );

    always #2 clk = ~clk;

    // scale by gain/256 with floor, add offset, saturate to out_w bits
    function automatic longint scale_clamp(input longint in_v, input longint gain,
                                           input longint offset, input int out_w);
        longint sum;
        longint hi;
        longint lo;
        sum = ((in_v * gain) >>> GAIN_RADIX) + offset;
        hi  = (longint'(1) <<< (out_w - 1)) - 1;
        lo  = -(longint'(1) <<< (out_w - 1));
        if (sum > hi) begin
            sum = hi;
        end else if (sum < lo) begin
            sum = lo;
        end
        return sum;
    endfunction

    // readable bits of each read-write register
    function automatic logic [31:0] field_mask(input logic [7:0] off);
        case (off)
            8'h00:                      field_mask = 32'h0000_00F7;
            8'h04, 8'h0C, 8'h18, 8'h24: field_mask = 32'h0000_00FF;
            8'h10, 8'h1C, 8'h20:        field_mask = 32'h0000_FFFF;
            8'h2C:                      field_mask = 32'h0000_0002;
            default:                    field_mask = 32'hFFFF_FFFF;
        endcase
    endfunction

    task automatic check_eq(input longint got, input longint exp, input string msg);
        checks++;
        if (got != exp) begin
            errors++;
            $display("Fail at %0t ns: %s (got %0d, expected %0d)", $time, msg, got, exp);
        end
    endtask

    task automatic report_test(input string name, input int err_before);
        $display("%s: done, %0d mismatches", name, errors - err_before);
    endtask

    task automatic apb_write(input logic [31:0] addr, input logic [31:0] data);
        @(negedge clk);
        psel    = 1'b1;
        pwrite  = 1'b1;
        penable = 1'b0;
        paddr   = addr;
        pwdata  = data;
        @(negedge clk);
        penable = 1'b1;
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_read(input logic [31:0] addr, output logic [31:0] data);
        @(negedge clk);
        psel    = 1'b1;
        pwrite  = 1'b0;
        penable = 1'b0;
        paddr   = addr;
        @(negedge clk);
        penable = 1'b1;
        // middle of the low phase, prdata settled
        #1;
        data = prdata;
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    // am factor of exactly 256
    task automatic set_unity_am(input logic [7:0] noise);
        apb_write(32'(AM_RAW), 32'h0);
        apb_write(32'(AM_GAIN), 32'h0);
        apb_write(32'(AM_OFFSET), 32'd256);
        apb_write(32'(NOISE_GAIN), {24'h0, noise});
    endtask

    task automatic test_readback();
        int          err0;
        logic [31:0] wr_val [16];
        logic [31:0] rd;
        err0 = errors;
        for (int off = 0; off <= 8'h38; off += 4) begin
            apb_read(32'(off), rd);
            check_eq(rd, 0, $sformatf("reset value at offset 0x%0h", off));
        end
        for (int round = 0; round < 3; round++) begin
            for (int off = 0; off <= 8'h30; off += 4) begin
                wr_val[off/4] = $random(seed);
                if (off != 8'h28) begin
                    apb_write(32'(off), wr_val[off/4]);
                end
            end
            for (int off = 0; off <= 8'h30; off += 4) begin
                if (off != 8'h28) begin
                    apb_read(32'(off), rd);
                    check_eq(rd, wr_val[off/4] & field_mask(8'(off)),
                             $sformatf("readback at offset 0x%0h", off));
                end
            end
        end
        apb_read(32'h3C, rd);
        check_eq(rd, 0, "unmapped offset 0x3c");
        apb_read(32'hFC, rd);
        check_eq(rd, 0, "unmapped offset 0xfc");
        apb_read(32'h104, rd);
        check_eq(rd, 0, "address above the register page");
        report_test("register readback", err0);
    endtask

    // out_sel INA, am_sel RAW, no noise
    task automatic test_am_ina();
        int                         err0;
        logic signed [SAMPLE_W-1:0] x;
        logic signed [SAMPLE_W-1:0] am_raw;
        logic signed [GAIN_W-1:0]   am_gain;
        logic signed [GAIN_W-1:0]   am_offset;
        longint                     am;
        err0 = errors;
        apb_write(32'(CTRL), 32'h02);
        apb_write(32'(NOISE_GAIN), 32'h0);
        for (int i = 0; i < 24; i++) begin
            x      = 8'($random(seed));
            am_raw = 8'($random(seed));
            // odd rounds use the full range so both rails get hit
            if (i % 2 == 0) begin
                am_gain   = 16'($random(seed) % 512);
                am_offset = 16'($random(seed) % 512);
            end else begin
                am_gain   = 16'($random(seed));
                am_offset = 16'($random(seed));
            end
            apb_write(32'(AM_RAW), 32'(am_raw));
            apb_write(32'(AM_GAIN), 32'(am_gain));
            apb_write(32'(AM_OFFSET), 32'(am_offset));
            @(negedge clk);
            ina_data = x;
            repeat (4) @(negedge clk);
            am = scale_clamp(am_raw, am_gain, am_offset, GAIN_W);
            check_eq(dds_data_out, scale_clamp(x, am, 0, SAMPLE_W), "ina through raw am");
        end
        report_test("pass-through and am clamping", err0);
    endtask

    // out_sel RAW, am_sel INB
    task automatic test_am_inb();
        int                         err0;
        logic signed [SAMPLE_W-1:0] raw;
        logic signed [SAMPLE_W-1:0] b;
        logic signed [GAIN_W-1:0]   am_gain;
        logic signed [GAIN_W-1:0]   am_offset;
        longint                     am;
        err0 = errors;
        apb_write(32'(CTRL), 32'h80);
        apb_write(32'(NOISE_GAIN), 32'h0);
        for (int i = 0; i < 20; i++) begin
            raw       = 8'($random(seed));
            b         = 8'($random(seed));
            am_gain   = 16'($random(seed) % 1024);
            am_offset = 16'($random(seed) % 512);
            apb_write(32'(RAW), 32'(raw));
            apb_write(32'(AM_GAIN), 32'(am_gain));
            apb_write(32'(AM_OFFSET), 32'(am_offset));
            @(negedge clk);
            inb_data = b;
            repeat (4) @(negedge clk);
            am = scale_clamp(b, am_gain, am_offset, GAIN_W);
            check_eq(dds_data_out, scale_clamp(raw, am, 0, SAMPLE_W), "raw with am from inb");
        end
        report_test("am from input", err0);
    endtask

    task automatic test_dds_fm();
        int                         err0;
        logic [7:0]                 k;
        logic [7:0]                 m;
        logic [7:0]                 exp_step;
        logic [7:0]                 d;
        logic signed [SAMPLE_W-1:0] prev;
        logic signed [SAMPLE_W-1:0] cur;
        err0 = errors;
        apb_write(32'(CTRL), 32'h0);
        // table entry i holds i, so the output is the top phase byte
        for (int i = 0; i < ROM_DEPTH; i++) begin
            apb_write(32'(ROM_WR), {16'h0, 8'(i), 8'(i)});
        end
        set_unity_am(8'h0);
        apb_write(32'(FM_RAW), 32'($random(seed)) & 32'hFF);
        apb_write(32'(FM_GAIN), 32'h0);
        for (int round = 0; round < 4; round++) begin
            k        = 8'($random(seed));
            m        = 8'($random(seed));
            exp_step = k + m;
            apb_write(32'(STEP), {k, 24'h0});
            apb_write(32'(FM_OFFSET), {m, 24'h0});
            apb_write(32'(CTRL), 32'h05);
            repeat (4) @(negedge clk);
            prev = dds_data_out;
            for (int i = 0; i < 16; i++) begin
                @(negedge clk);
                cur = dds_data_out;
                d   = cur - prev;
                check_eq(d, exp_step, $sformatf("dds step with k=%0d m=%0d", k, m));
                prev = cur;
            end
        end
        apb_write(32'(CTRL), 32'h0);
        report_test("dds stepping and fm", err0);
    endtask

    task automatic test_stats();
        int                         err0;
        int                         polls;
        bit                         reached;
        logic signed [SAMPLE_W-1:0] v;
        logic signed [SAMPLE_W-1:0] lo;
        logic signed [SAMPLE_W-1:0] hi;
        logic [31:0]                rd;
        logic [31:0]                limit;
        err0 = errors;
        apb_write(32'(CTRL), 32'h02);
        set_unity_am(8'h0);
        @(negedge clk);
        v        = 8'($random(seed));
        ina_data = v;
        lo       = v;
        hi       = v;
        repeat (4) @(negedge clk);
        apb_write(32'(STAT_LIMIT), 32'hFFFF_FFFF);
        apb_write(32'(STAT_CTRL), 32'h3);
        for (int i = 0; i < 12; i++) begin
            @(negedge clk);
            v        = 8'($random(seed));
            ina_data = v;
            if (v < lo) begin
                lo = v;
            end
            if (v > hi) begin
                hi = v;
            end
            repeat (4) @(negedge clk);
        end
        apb_read(32'(STAT_MINMAX), rd);
        check_eq($signed(rd[7:0]), lo, "statistics minimum");
        check_eq($signed(rd[15:8]), hi, "statistics maximum");
        check_eq(rd[31:16], 0, "upper bits of min/max register");

        // small limit, count must stop there
        limit = 32'(1 + ($random(seed) & 15));
        apb_write(32'(STAT_LIMIT), limit);
        apb_write(32'(STAT_CTRL), 32'h3);
        reached = 1'b0;
        for (polls = 0; polls < 100 && !reached; polls++) begin
            apb_read(32'(STAT_COUNT), rd);
            if (rd == limit) begin
                reached = 1'b1;
            end
        end
        if (!reached) begin
            errors++;
            $display("timeout: statistics count never reached the limit of %0d", limit);
        end else begin
            repeat (8) @(negedge clk);
            apb_read(32'(STAT_COUNT), rd);
            check_eq(rd, limit, "statistics count held at limit");
        end
        report_test("statistics", err0);
    endtask

    task automatic test_noise();
        int                         err0;
        int                         mag;
        bit                         varied;
        logic signed [SAMPLE_W-1:0] g;
        logic signed [SAMPLE_W-1:0] x;
        logic signed [SAMPLE_W-1:0] first;
        logic signed [SAMPLE_W-1:0] v;
        longint                     lo_lim;
        longint                     hi_lim;
        err0 = errors;
        g = 8'($random(seed));
        if (g == 0) begin
            g = 8'sd5;
        end
        x   = 8'($random(seed) % 100);
        mag = int'(g);
        if (mag < 0) begin
            mag = -mag;
        end
        // unity scale so only the saturation applies
        lo_lim = scale_clamp(int'(x) - (mag / 2 + 1), 256, 0, SAMPLE_W);
        hi_lim = scale_clamp(int'(x) + (mag / 2 + 1), 256, 0, SAMPLE_W);
        apb_write(32'(CTRL), 32'h02);
        set_unity_am(g);
        @(negedge clk);
        ina_data = x;
        repeat (4) @(negedge clk);
        varied = 1'b0;
        first  = dds_data_out;
        for (int i = 0; i < 64; i++) begin
            @(negedge clk);
            v = dds_data_out;
            check_eq(v >= lo_lim && v <= hi_lim, 1,
                     $sformatf("noisy output %0d outside [%0d, %0d]", v, lo_lim, hi_lim));
            if (v != first) begin
                varied = 1'b1;
            end
        end
        check_eq(varied, 1, "noise never changed the output");
        report_test("noise bound", err0);
    endtask

    initial begin
        clk      = 1'b0;
        rst_n    = 1'b0;
        psel     = 1'b0;
        penable  = 1'b0;
        pwrite   = 1'b0;
        paddr    = '0;
        pwdata   = '0;
        ina_data = '0;
        inb_data = '0;
        repeat (5) @(negedge clk);
        rst_n = 1'b1;
        repeat (2) @(negedge clk);
        check_eq(dds_data_out, 0, "output after reset");

        test_readback();
        test_am_ina();
        test_am_inb();
        test_dds_fm();
        test_stats();
        test_noise();

        $display("%0d checks, %0d mismatches", checks, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// File: project.f
rtl/dds_pkg.sv
rtl/gain_offset_clamp.sv
rtl/dds_regs.sv
rtl/dds_core.sv
rtl/signal_mixer.sv
rtl/sig_stats.sv
rtl/dds_block.sv
test/tb_dds_block.sv

// File: Makefile
TOP := tb_dds_block

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f project.f \
		--top-module $(TOP) -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^test passed$$" sim.log

clean:
	rm -rf obj_dir sim.log
